// ==== ibuf_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// ibuf sizing constants
////////////////////////////////////////////////////////////////////////////

`ifndef IBUF_CONSTS_SVH
`define IBUF_CONSTS_SVH

// buffer geometry
`define IBUF_AW      10                 // address bits
`define IBUF_DEPTH   1024               // words, 2**IBUF_AW

// datapath
`define WORD_W       64                 // stream and buffer word

// back-pressure
// receive stops once fewer than this many words are free;
// covers the pipeline from pointer update to tready falling
`define IBUF_MARGIN  10

`endif

// ==== ibuf_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// ibuf shared types
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "ibuf_consts.svh"

package ibuf_pkg;

    typedef logic [`WORD_W-1:0]  word_t;
    typedef logic [`IBUF_AW-1:0] ibuf_addr_t;
    typedef logic [`IBUF_AW:0]   ibuf_ptr_t;      // msb is the wrap bit
    typedef logic [15:0]         pkt_len_t;       // bytes
    typedef logic [7:0]          port_t;

    localparam int unsigned DESC_LEN_LSB = 32;    // len field in descriptor word

    // same layout as tuser[95:0]
    typedef struct packed {
        logic [63:0] ts;                          // tuser[95:32]
        port_t       dst_port;                    // tuser[31:24]
        port_t       src_port;                    // tuser[23:16]
        pkt_len_t    len;                         // tuser[15:0]
    } pkt_meta_t;

    typedef struct packed {
        logic       en;
        ibuf_addr_t addr;
        word_t      data;
    } buf_wr_t;

    typedef struct packed {
        logic init;                               // clear all pointers
        logic data_step;                          // one data word written
        logic commit;                             // packet complete, publish
    } ptr_cmd_t;

    typedef enum logic [2:0] {
        RX_INIT, RX_WAIT_HOST, RX_RECV, RX_PAUSED, RX_WR_DESC, RX_WR_TS
    } rx_state_e;

    typedef enum logic [1:0] {
        DR_IDLE, DR_RD_DESC, DR_RD_TS, DR_RD_DATA
    } drain_state_e;

    // bytes to 64-bit words, rounded up
    function automatic pkt_len_t len_to_words(input pkt_len_t len);
        logic [16:0] sum;
        sum = {1'b0, len} + 17'd7;
        return pkt_len_t'(sum[16:3]);
    endfunction

endpackage

`default_nettype wire

// ==== ibuf_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// ibuf memory, simple dual port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_consts.svh"

module ibuf_ram import ibuf_pkg::*; (
    input  wire             clk,
    input  wire buf_wr_t    buf_wr,       // from rx FSM
    input  wire             rd_en,        // from drain
    input  wire ibuf_addr_t rd_addr,
    output word_t           rd_data       // one cycle after rd_en
);

    word_t mem [`IBUF_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (buf_wr.en) begin
            mem[buf_wr.addr] <= buf_wr.data;
        end
    end

    // read port, output holds while rd_en low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // old data on same-address collision
        end
    end

endmodule

`default_nettype wire

// ==== ibuf_ptr_tracker.sv ====
////////////////////////////////////////////////////////////////////////////
// ibuf write and commit pointers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_consts.svh"

module ibuf_ptr_tracker import ibuf_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire ptr_cmd_t  ptr_cmd,
    input  wire ibuf_ptr_t committed_cons,    // from drain
    output ibuf_ptr_t      wr_ptr,
    output ibuf_ptr_t      hdr_ptr,
    output ibuf_ptr_t      committed_prod,
    output logic           almost_full
);

    localparam int unsigned HDR_WORDS = 2;    // descriptor + timestamp
    localparam ibuf_ptr_t   AF_LIMIT  = ibuf_ptr_t'(`IBUF_DEPTH - `IBUF_MARGIN);
    localparam ibuf_ptr_t   MAX_OCC   = ibuf_ptr_t'(`IBUF_DEPTH);

    ibuf_ptr_t occ_next;
    ibuf_ptr_t occupancy;                     // words claimed, incl. open packet

    // wrap bit makes plain subtraction correct
    assign occ_next = wr_ptr - committed_cons;

    ////////////////////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || ptr_cmd.init) begin
            wr_ptr         <= ibuf_ptr_t'(HDR_WORDS);  // first data after header
            hdr_ptr        <= '0;
            committed_prod <= '0;
        end else if (ptr_cmd.commit) begin
            committed_prod <= wr_ptr;         // packet visible to drain
            hdr_ptr        <= wr_ptr;         // next packet header here
            wr_ptr         <= wr_ptr + ibuf_ptr_t'(HDR_WORDS);
        end else if (ptr_cmd.data_step) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy   <= '0;
            almost_full <= 1'b0;
        end else begin
            occupancy   <= occ_next;
            almost_full <= (occ_next > AF_LIMIT);   // registered compare
        end
    end

    // back-pressure loop through the FSM keeps writer behind reader
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        occupancy <= MAX_OCC)
        else $error("ibuf_ptr_tracker: occupancy beyond buffer depth");

endmodule

`default_nettype wire

// ==== rx_ctrl_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// receive FSM, backend stream into ibuf
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_consts.svh"

module rx_ctrl_fsm import ibuf_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    // backend stream
    input  wire word_t  s_axis_tdata,
    input  wire pkt_meta_t meta,             // low tuser bits
    input  wire         s_axis_tvalid,
    input  wire         s_axis_tlast,
    output logic        s_axis_tready,
    // host and pointer status
    input  wire         hst_rdy,
    input  wire         almost_full,
    input  wire ibuf_ptr_t wr_ptr,           // next data slot
    input  wire ibuf_ptr_t hdr_ptr,          // descriptor slot of this packet
    // commands out
    output ptr_cmd_t    ptr_cmd,
    output buf_wr_t     buf_wr
);

    rx_state_e  state;
    logic       hst_rdy_q1;
    logic       hst_rdy_q2;
    logic       first_q;                     // next accepted word opens a packet
    pkt_meta_t  meta_q;
    pkt_len_t   pkt_words;                   // data words so far in packet
    pkt_len_t   cur_len;
    logic       accept;
    ibuf_ptr_t  ts_ptr;
    logic       wr_en;
    ibuf_addr_t wr_addr;
    word_t      wr_data;

    assign accept  = (state == RX_RECV) && s_axis_tvalid && s_axis_tready;
    assign ts_ptr  = hdr_ptr + 1'b1;         // timestamp right after descriptor
    assign cur_len = first_q ? meta.len : meta_q.len;

    assign ptr_cmd = '{init:      (state == RX_INIT),
                       data_step: accept,
                       commit:    (state == RX_WR_TS)};

    assign buf_wr  = '{en: wr_en, addr: wr_addr, data: wr_data};

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RX_INIT;
            s_axis_tready <= 1'b0;
            wr_en         <= 1'b0;
            hst_rdy_q1    <= 1'b0;
            hst_rdy_q2    <= 1'b0;
            first_q       <= 1'b1;
            pkt_words     <= '0;
        end else begin
            hst_rdy_q1 <= hst_rdy;           // async level from host side
            hst_rdy_q2 <= hst_rdy_q1;
            wr_en      <= 1'b0;

            if (accept) begin
                first_q   <= s_axis_tlast;
                pkt_words <= s_axis_tlast ? '0 : pkt_words + 1'b1;
            end

            case (state)
                RX_INIT: begin
                    state <= RX_WAIT_HOST;   // pointers cleared this cycle
                end
                RX_WAIT_HOST: begin
                    if (hst_rdy_q2) begin
                        s_axis_tready <= 1'b1;
                        state         <= RX_RECV;
                    end
                end
                RX_RECV: begin
                    wr_en <= accept;
                    if (accept && s_axis_tlast) begin
                        s_axis_tready <= 1'b0;   // two header cycles follow
                        state         <= RX_WR_DESC;
                    end else if (almost_full) begin
                        s_axis_tready <= 1'b0;
                        state         <= RX_PAUSED;
                    end
                end
                RX_PAUSED: begin
                    if (!almost_full) begin
                        s_axis_tready <= 1'b1;
                        state         <= RX_RECV;
                    end
                end
                RX_WR_DESC: begin
                    wr_en <= 1'b1;
                    state <= RX_WR_TS;
                end
                RX_WR_TS: begin
                    wr_en <= 1'b1;               // commit pulses now
                    if (almost_full) begin
                        state <= RX_PAUSED;
                    end else begin
                        s_axis_tready <= 1'b1;
                        state         <= RX_RECV;
                    end
                end
                default: begin
                    s_axis_tready <= 1'b0;
                    state         <= RX_INIT;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // metadata and write payload
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept && first_q) begin
            meta_q <= meta;                  // tuser valid with first beat
        end
        case (state)
            RX_WR_DESC: begin
                wr_addr <= hdr_ptr[`IBUF_AW-1:0];
                wr_data <= {16'h0, meta_q.len, 8'h0, meta_q.dst_port,
                            8'h0, meta_q.src_port};
            end
            RX_WR_TS: begin
                wr_addr <= ts_ptr[`IBUF_AW-1:0];
                wr_data <= meta_q.ts;
            end
            default: begin
                wr_addr <= wr_ptr[`IBUF_AW-1:0];
                wr_data <= s_axis_tdata;
            end
        endcase
    end

    // nothing reaches the buffer before the host is up
    a_no_wr_before_host: assert property (@(posedge clk) disable iff (rst)
        (state == RX_WAIT_HOST) |-> !buf_wr.en && !s_axis_tready)
        else $error("rx_ctrl_fsm: write or tready while waiting for host");

    // beat count agrees with tuser length
    a_len_matches: assert property (@(posedge clk) disable iff (rst)
        (accept && s_axis_tlast) |-> (pkt_words + 1'b1 == len_to_words(cur_len)))
        else $error("rx_ctrl_fsm: packet beats disagree with length");

endmodule

`default_nettype wire

// ==== ibuf_drain.sv ====
////////////////////////////////////////////////////////////////////////////
// ibuf drain to host port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_consts.svh"

module ibuf_drain import ibuf_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            host_hold,        // pause level
    input  wire ibuf_ptr_t committed_prod,
    output ibuf_ptr_t      committed_cons,
    // buffer read port
    output logic           rd_en,
    output ibuf_addr_t     rd_addr,
    input  wire word_t     rd_data,
    // host side
    output word_t          host_data,
    output logic           host_valid,
    output logic           host_first,
    output logic           host_last
);

    drain_state_e state;
    ibuf_ptr_t    rd_ptr;                    // next word to read
    pkt_len_t     words_left;                // data reads still to issue
    logic         pend;                      // rd_data not yet shown
    logic         pend_first;
    logic         pend_last;

    assign rd_en      = (state != DR_IDLE) && !host_hold;
    assign rd_addr    = rd_ptr[`IBUF_AW-1:0];
    assign host_data  = rd_data;
    assign host_valid = pend && !host_hold;  // held word waits in ram reg
    assign host_first = host_valid && pend_first;
    assign host_last  = host_valid && pend_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= DR_IDLE;
            rd_ptr         <= '0;
            committed_cons <= '0;
            words_left     <= '0;
            pend           <= 1'b0;
            pend_first     <= 1'b0;
            pend_last      <= 1'b0;
        end else begin
            // tag each read for the cycle its word shows up
            if (rd_en) begin
                pend       <= 1'b1;
                rd_ptr     <= rd_ptr + 1'b1;
                pend_first <= (state == DR_RD_DESC);
                pend_last  <= (state == DR_RD_DATA) && (words_left <= 16'd1);
            end else if (host_valid) begin
                pend <= 1'b0;
            end

            // word count from returned descriptor
            if (host_first) begin
                words_left <= len_to_words(rd_data[DESC_LEN_LSB +: $bits(pkt_len_t)]);
            end else if (rd_en && (state == DR_RD_DATA)) begin
                words_left <= words_left - 1'b1;
            end

            // rd_ptr sits just past the packet here
            if (host_last) begin
                committed_cons <= rd_ptr;
            end

            case (state)
                DR_IDLE: begin
                    if (committed_prod != rd_ptr) begin
                        state <= DR_RD_DESC;
                    end
                end
                DR_RD_DESC: begin
                    if (rd_en) state <= DR_RD_TS;
                end
                DR_RD_TS: begin
                    if (rd_en) state <= DR_RD_DATA;
                end
                DR_RD_DATA: begin
                    if (rd_en && (words_left <= 16'd1)) begin
                        state <= DR_IDLE;
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    // released packet stays inside the committed region
    a_cons_behind_prod: assert property (@(posedge clk) disable iff (rst)
        host_last |-> (ibuf_ptr_t'(rd_ptr - committed_cons)
                       <= ibuf_ptr_t'(committed_prod - committed_cons)))
        else $error("ibuf_drain: consumer pointer passes producer");

endmodule

`default_nettype wire

// ==== bkd_rx_top.sv ====
////////////////////////////////////////////////////////////////////////////
// backend receive path top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bkd_rx_top import ibuf_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    // backend stream
    input  wire word_t   s_axis_tdata,
    input  wire [127:0]  s_axis_tuser,
    input  wire          s_axis_tvalid,
    input  wire          s_axis_tlast,
    output logic         s_axis_tready,
    // host side
    input  wire          hst_rdy,
    input  wire          host_hold,
    output word_t        host_data,
    output logic         host_valid,
    output logic         host_first,
    output logic         host_last
);

    pkt_meta_t  meta;
    ptr_cmd_t   ptr_cmd;
    buf_wr_t    buf_wr;
    ibuf_ptr_t  wr_ptr;
    ibuf_ptr_t  hdr_ptr;
    ibuf_ptr_t  committed_prod;
    ibuf_ptr_t  committed_cons;
    logic       almost_full;
    logic       rd_en;
    ibuf_addr_t rd_addr;
    word_t      rd_data;

    // upper tuser bits carry nothing here
    assign meta = pkt_meta_t'(s_axis_tuser[$bits(pkt_meta_t)-1:0]);

    rx_ctrl_fsm u_rx_fsm (
        .clk, .rst, .s_axis_tdata, .meta, .s_axis_tvalid, .s_axis_tlast,
        .s_axis_tready, .hst_rdy, .almost_full, .wr_ptr, .hdr_ptr,
        .ptr_cmd, .buf_wr
    );

    ibuf_ptr_tracker u_ptrs (
        .clk, .rst, .ptr_cmd, .committed_cons, .wr_ptr, .hdr_ptr,
        .committed_prod, .almost_full
    );

    ibuf_ram u_ram (
        .clk, .buf_wr, .rd_en, .rd_addr, .rd_data
    );

    ibuf_drain u_drain (
        .clk, .rst, .host_hold, .committed_prod, .committed_cons,
        .rd_en, .rd_addr, .rd_data,
        .host_data, .host_valid, .host_first, .host_last
    );

endmodule

`default_nettype wire

// ==== tb_bkd_rx.sv ====
////////////////////////////////////////////////////////////////////////////
// backend receive path testbench
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "ibuf_consts.svh"

module tb_bkd_rx import ibuf_pkg::*; ();

    localparam int N_RAND_PKTS    = 40;            // gaps, mixed lengths
    localparam int N_HOLD_PKTS    = 50;            // long packets behind a held drain
    localparam int N_PKTS         = N_RAND_PKTS + N_HOLD_PKTS;
    localparam int TIMEOUT_CYCLES = N_PKTS * 300 + 5000;

    // one word as the host side should show it
    typedef struct packed {
        word_t data;
        logic  first;
        logic  last;
    } host_word_t;

    logic         clk;
    logic         rst;
    word_t        s_axis_tdata;
    logic [127:0] s_axis_tuser;
    logic         s_axis_tvalid;
    logic         s_axis_tlast;
    logic         s_axis_tready;
    logic         hst_rdy;
    logic         host_hold;
    word_t        host_data;
    logic         host_valid;
    logic         host_first;
    logic         host_last;

    host_word_t   exp_q[$];                        // scoreboard, in send order
    host_word_t   exp_w;
    int           model_occ;                       // claimed buffer words
    int           drained;                         // words shown of current packet
    logic         long_hold;
    logic         saw_stall;

    bkd_rx_top DUT (
        .clk, .rst, .s_axis_tdata, .s_axis_tuser, .s_axis_tvalid, .s_axis_tlast,
        .s_axis_tready, .hst_rdy, .host_hold, .host_data, .host_valid,
        .host_first, .host_last
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;                     // 8 ns period
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_run($sformatf("** Error at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // packet generator
    ////////////////////////////////////////////////////////////////////////////
    task automatic send_packet(input int len, input int gap_pct);
        pkt_meta_t  meta;
        host_word_t hw;
        word_t      desc;
        int         nwords;
        int         i;
        meta.len      = pkt_len_t'(len);
        meta.src_port = port_t'($urandom);
        meta.dst_port = port_t'($urandom);
        meta.ts       = {$urandom, $urandom};
        nwords        = (len + 7) / 8;             // bytes to words, rounded up
        desc          = '0;
        desc[47:32]   = meta.len;
        desc[23:16]   = meta.dst_port;
        desc[7:0]     = meta.src_port;
        exp_q.push_back('{data: desc, first: 1'b1, last: 1'b0});
        exp_q.push_back('{data: meta.ts, first: 1'b0, last: 1'b0});
        for (i = 0; i < nwords; i++) begin
            while ($urandom_range(99) < gap_pct) begin
                s_axis_tvalid = 1'b0;              // idle beat
                @(negedge clk);
            end
            hw = '{data: {$urandom, $urandom}, first: 1'b0, last: (i == nwords - 1)};
            exp_q.push_back(hw);
            s_axis_tdata  = hw.data;
            s_axis_tuser  = {$urandom, meta};      // upper bits are junk
            s_axis_tlast  = hw.last;
            s_axis_tvalid = 1'b1;
            @(posedge clk);
            while (!s_axis_tready) @(posedge clk);
            @(negedge clk);
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    initial begin : stimulus
        int n;
        int len;
        void'($urandom(32'h82c1));
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tuser  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        hst_rdy       = 1'b0;
        host_hold     = 1'b0;
        long_hold     = 1'b0;
        saw_stall     = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (n = 0; n < N_RAND_PKTS; n++) begin
            if (n % 5 == 0) len = $urandom_range(8, 1);      // single word
            else            len = $urandom_range(200, 1);
            send_packet(len, 30);
        end
        long_hold = 1'b1;
        for (n = 0; n < N_HOLD_PKTS; n++) begin
            send_packet($urandom_range(200, 160), 0);        // fill fast
        end
        wait (exp_q.size() == 0);
        repeat (20) @(posedge clk);
        if (saw_stall) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run("tready never dropped while host_hold was held high");
        end
    end

    // first packet already waits with tvalid high
    initial begin : host_ready
        wait (rst === 1'b0);
        repeat (24) @(negedge clk);
        hst_rdy = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // host_hold bursts, then one long stretch until back-pressure
    ////////////////////////////////////////////////////////////////////////////
    initial begin : hold_ctrl
        int stall;
        wait (rst === 1'b0);
        while (!long_hold) begin
            @(negedge clk);
            host_hold = 1'b1;
            repeat ($urandom_range(12, 1)) @(negedge clk);
            host_hold = 1'b0;
            repeat ($urandom_range(30, 1)) @(negedge clk);
        end
        host_hold = 1'b1;
        stall     = 0;
        while (stall < 40) begin
            @(posedge clk);
            stall = (s_axis_tvalid && !s_axis_tready) ? stall + 1 : 0;
        end
        saw_stall = 1'b1;                          // buffer full, receive stopped
        @(negedge clk);
        host_hold = 1'b0;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("watchdog: run did not end within %0d cycles", TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////////////////////////////////////////
    // host monitor and occupancy model
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : host_monitor
        if (rst) begin
            model_occ = 2;                         // header slots of first packet
            drained   = 0;
        end else begin
            if (s_axis_tvalid && s_axis_tready) begin
                model_occ = model_occ + (s_axis_tlast ? 3 : 1);  // tlast claims next header
            end
            if (host_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("host_valid with no word outstanding in the scoreboard");
                end else begin
                    exp_w = exp_q.pop_front();
                    check_field(exp_w.first ? "host_data (descriptor)" : "host_data",
                                exp_w.data, host_data);
                    check_field("host_first", word_t'(exp_w.first), word_t'(host_first));
                    check_field("host_last", word_t'(exp_w.last), word_t'(host_last));
                    if (host_last) begin
                        model_occ = model_occ - (drained + 1);   // whole packet freed
                        drained   = 0;
                    end else begin
                        drained = drained + 1;
                    end
                end
            end
        end
    end

    a_tready_waits_host: assert property (@(posedge clk) disable iff (rst)
        !hst_rdy |-> !s_axis_tready)
        else fail_run($sformatf("** Error at %0t: s_axis_tready expected 0, got 1", $time));

    a_tready_after_host: assert property (@(posedge clk) disable iff (rst)
        $rose(hst_rdy) |-> ##[1:3] s_axis_tready)
        else fail_run($sformatf("** Error at %0t: s_axis_tready expected 1, got 0", $time));

    // descriptor and timestamp cycles
    a_header_gap: assert property (@(posedge clk) disable iff (rst)
        (s_axis_tvalid && s_axis_tready && s_axis_tlast) |=> !s_axis_tready [*2])
        else fail_run($sformatf("** Error at %0t: s_axis_tready expected 0, got 1", $time));

    a_model_occupancy: assert property (@(posedge clk) disable iff (rst)
        model_occ <= `IBUF_DEPTH)
        else fail_run($sformatf("** Error at %0t: model_occ expected <= %0d, got %0d",
                                $time, `IBUF_DEPTH, model_occ));

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
ibuf_pkg.sv
ibuf_ram.sv
ibuf_ptr_tracker.sv
rx_ctrl_fsm.sv
ibuf_drain.sv
bkd_rx_top.sv
tb_bkd_rx.sv

// ==== Bender.yml ====
package:
  name: bkd_rx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ibuf_pkg.sv
      - ibuf_ram.sv
      - ibuf_ptr_tracker.sv
      - rx_ctrl_fsm.sv
      - ibuf_drain.sv
      - bkd_rx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_bkd_rx.sv
